// ==== source/lc3b_pkg.sv ====
package lc3b_pkg;

	localparam int WORD_WIDTH = 16;
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	// memories are word indexed, byte address bit 0 dropped
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	typedef logic [WORD_WIDTH-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// z set out of reset
	localparam lc3b_nzp RESET_CC = 3'b010;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_and  = 2'b01,
		alu_not  = 2'b10,
		alu_pass = 2'b11
	} lc3b_alu_op;

	// operate format, low field is imm5 or {2'b00, sr2}
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm;
		logic [4:0] imm5_sr2;
	} lc3b_op_view;

	// memory and branch format
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_nzp dr_nzp;
		lc3b_reg base;
		logic [5:0] offset6;
	} lc3b_mem_view;

	typedef union packed {
		lc3b_op_view op;
		lc3b_mem_view mem;
	} lc3b_instr;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_alu_op alu_op;
		logic use_imm;
		logic load_regfile;
		logic load_cc;
		logic mem_read;
		logic mem_write;
		logic is_branch;
		logic addr_base_pc;
	} lc3b_control_word;

endpackage

// ==== source/lc3b_fetch.sv ====
`timescale 1ns/1ps

module lc3b_fetch import lc3b_pkg::*; (
	input logic clk,
	input logic rst,
	input logic prog_we,
	input lc3b_word prog_addr,
	input lc3b_word prog_data,
	input logic stall,
	input logic redirect,
	input lc3b_word redirect_pc,
	output logic fd_valid,
	output lc3b_word fd_pc,
	output lc3b_word fd_ir
);

	// unloaded words read as BR with an empty mask
	lc3b_word imem [IMEM_DEPTH] = '{default: '0};
	lc3b_word pc;
	lc3b_word pc_next;

	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr[IMEM_AW:1]] <= prog_data;
		end
	end

	assign pc_next = pc + 16'd2;

	// redirect wins over stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			fd_valid <= 1'b0;
		end else if (redirect) begin
			pc <= redirect_pc;
			fd_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc_next;
			fd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_pc <= pc_next;
			fd_ir <= imem[pc[IMEM_AW:1]];
		end
	end

endmodule

// ==== source/lc3b_regfile.sv ====
`timescale 1ns/1ps

module lc3b_regfile import lc3b_pkg::*; (
	input logic clk,
	input logic rst,
	input lc3b_reg sr1,
	input lc3b_reg sr2,
	output lc3b_word sr1_data,
	output lc3b_word sr2_data,
	output lc3b_nzp cc,
	input logic wb_valid,
	input lc3b_reg wb_dr,
	input lc3b_word wb_data,
	input lc3b_nzp wb_cc
);

	lc3b_word regs [8];
	lc3b_nzp cc_reg;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			cc_reg <= RESET_CC;
		end else if (wb_valid) begin
			regs[wb_dr] <= wb_data;
			cc_reg <= wb_cc;
		end
	end

	// write back visible to a read in the same cycle
	assign sr1_data = (wb_valid && wb_dr == sr1) ? wb_data : regs[sr1];
	assign sr2_data = (wb_valid && wb_dr == sr2) ? wb_data : regs[sr2];
	assign cc = wb_valid ? wb_cc : cc_reg;

endmodule

// ==== source/lc3b_decode.sv ====
`timescale 1ns/1ps

module lc3b_decode import lc3b_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fd_valid,
	input lc3b_word fd_pc,
	input lc3b_word fd_ir,
	input logic ex_valid,
	input lc3b_reg ex_dr,
	input logic ex_mem_read,
	input logic redirect,
	output lc3b_reg sr1,
	output lc3b_reg sr2,
	input lc3b_word sr1_data,
	input lc3b_word sr2_data,
	input lc3b_nzp cc,
	output logic stall,
	output logic de_valid,
	output lc3b_control_word de_cw,
	output lc3b_word de_pc,
	output lc3b_word de_ir,
	output lc3b_word de_op1,
	output lc3b_word de_op2,
	output lc3b_nzp de_cc,
	output lc3b_reg de_dr,
	output lc3b_reg de_sr1,
	output lc3b_reg de_sr2
);

	lc3b_instr instr;
	lc3b_control_word cw;
	logic use_sr1;
	logic use_sr2;
	logic load_use;
	logic cc_pending;
	logic cc_in_mem;

	assign instr = fd_ir;
	assign sr1 = instr.op.sr1;
	// STR reads the register named in its dr field
	assign sr2 = (instr.op.opcode == op_str) ? instr.mem.dr_nzp : instr.op.imm5_sr2[2:0];

	always_comb begin
		cw = '0;
		cw.opcode = instr.op.opcode;
		use_sr1 = 1'b0;
		use_sr2 = 1'b0;
		case (instr.op.opcode)
			op_add, op_and: begin
				cw.alu_op = (instr.op.opcode == op_add) ? alu_add : alu_and;
				cw.use_imm = instr.op.imm;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = !instr.op.imm;
			end
			op_not: begin
				cw.alu_op = alu_not;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			op_lea: begin
				cw.alu_op = alu_pass;
				cw.addr_base_pc = 1'b1;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			op_ldr: begin
				cw.alu_op = alu_pass;
				cw.mem_read = 1'b1;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			op_str: begin
				cw.mem_write = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = 1'b1;
			end
			op_br: begin
				cw.is_branch = 1'b1;
				cw.addr_base_pc = 1'b1;
			end
			default: ;
		endcase
	end

	assign load_use = ex_valid && ex_mem_read
		&& ((use_sr1 && ex_dr == sr1) || (use_sr2 && ex_dr == sr2));

	// branch holds until older cc writes reach write back
	assign cc_pending = cw.is_branch && (instr.mem.dr_nzp != 3'b000)
		&& ((ex_valid && de_cw.load_cc) || cc_in_mem);

	assign stall = fd_valid && (load_use || cc_pending);

	always_ff @(posedge clk) begin
		if (rst) begin
			de_valid <= 1'b0;
			cc_in_mem <= 1'b0;
		end else begin
			de_valid <= fd_valid && !stall && !redirect;
			cc_in_mem <= ex_valid && de_cw.load_cc;
		end
	end

	always_ff @(posedge clk) begin
		de_cw <= cw;
		de_pc <= fd_pc;
		de_ir <= fd_ir;
		de_op1 <= sr1_data;
		de_op2 <= sr2_data;
		de_cc <= cc;
		de_dr <= instr.mem.dr_nzp;
		de_sr1 <= sr1;
		de_sr2 <= sr2;
	end

endmodule

// ==== source/lc3b_forward.sv ====
`timescale 1ns/1ps

module lc3b_forward import lc3b_pkg::*; (
	input lc3b_reg de_sr1,
	input lc3b_reg de_sr2,
	input lc3b_word de_op1,
	input lc3b_word de_op2,
	input logic em_valid,
	input logic em_load_regfile,
	input logic em_mem_read,
	input lc3b_reg em_dr,
	input lc3b_word em_result,
	input logic mw_valid,
	input lc3b_reg mw_dr,
	input lc3b_word mw_data,
	output lc3b_word op1,
	output lc3b_word op2
);

	logic em_source;

	// load data is not ready here, the stall covers it
	assign em_source = em_valid && em_load_regfile && !em_mem_read;

	// younger producer checked first
	function automatic lc3b_word pick(input lc3b_reg src, input lc3b_word latched);
		if (em_source && em_dr == src) begin
			return em_result;
		end
		if (mw_valid && mw_dr == src) begin
			return mw_data;
		end
		return latched;
	endfunction

	always_comb begin
		op1 = pick(de_sr1, de_op1);
		op2 = pick(de_sr2, de_op2);
	end

endmodule

// ==== source/lc3b_execute.sv ====
`timescale 1ns/1ps

module lc3b_execute import lc3b_pkg::*; (
	input logic clk,
	input logic rst,
	input logic de_valid,
	input lc3b_control_word de_cw,
	input lc3b_word de_pc,
	input lc3b_word de_ir,
	input lc3b_nzp de_cc,
	input lc3b_reg de_dr,
	input lc3b_word op1,
	input lc3b_word op2,
	output logic redirect,
	output lc3b_word redirect_pc,
	output logic em_valid,
	output logic em_load_regfile,
	output logic em_mem_read,
	output lc3b_control_word em_cw,
	output lc3b_reg em_dr,
	output lc3b_word em_result,
	output lc3b_word em_address,
	output lc3b_word em_store_data
);

	lc3b_instr instr;
	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word offset9;
	lc3b_word alu_b;
	lc3b_word address;
	lc3b_word result;

	assign instr = de_ir;
	assign imm5 = {{11{instr.op.imm5_sr2[4]}}, instr.op.imm5_sr2};
	assign offset6 = {{10{instr.mem.offset6[5]}}, instr.mem.offset6};
	// 9-bit offset spans base and offset fields
	assign offset9 = {{7{instr.mem.base[2]}}, instr.mem.base, instr.mem.offset6};

	assign alu_b = de_cw.use_imm ? imm5 : op2;

	// word offsets
	assign address = de_cw.addr_base_pc ? de_pc + {offset9[14:0], 1'b0}
		: op1 + {offset6[14:0], 1'b0};

	always_comb begin
		unique case (de_cw.alu_op)
			alu_add: result = op1 + alu_b;
			alu_and: result = op1 & alu_b;
			alu_not: result = ~op1;
			alu_pass: result = address;
		endcase
	end

	assign redirect = de_valid && de_cw.is_branch && |(instr.mem.dr_nzp & de_cc);
	assign redirect_pc = address;

	always_ff @(posedge clk) begin
		if (rst) begin
			em_valid <= 1'b0;
		end else begin
			em_valid <= de_valid;
		end
	end

	always_ff @(posedge clk) begin
		em_cw <= de_cw;
		em_dr <= de_dr;
		em_result <= result;
		em_address <= address;
		em_store_data <= op2;
	end

	assign em_load_regfile = em_cw.load_regfile;
	assign em_mem_read = em_cw.mem_read;

endmodule

// ==== source/lc3b_memory.sv ====
`timescale 1ns/1ps

module lc3b_memory import lc3b_pkg::*; (
	input logic clk,
	input logic rst,
	input logic em_valid,
	input lc3b_control_word em_cw,
	input lc3b_reg em_dr,
	input lc3b_word em_result,
	input lc3b_word em_address,
	input lc3b_word em_store_data,
	output logic mw_valid,
	output lc3b_reg mw_dr,
	output lc3b_word mw_data,
	output lc3b_nzp mw_cc
);

	lc3b_word dmem [DMEM_DEPTH];
	lc3b_word rdata;
	lc3b_word value;
	lc3b_nzp value_cc;

	assign rdata = dmem[em_address[DMEM_AW:1]];
	assign value = em_cw.mem_read ? rdata : em_result;

	always_comb begin
		if (value[WORD_WIDTH-1]) begin
			value_cc = 3'b100;
		end else if (value == '0) begin
			value_cc = 3'b010;
		end else begin
			value_cc = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (em_valid && em_cw.mem_write) begin
			dmem[em_address[DMEM_AW:1]] <= em_store_data;
		end
	end

	// only register writes go on to write back
	always_ff @(posedge clk) begin
		if (rst) begin
			mw_valid <= 1'b0;
		end else begin
			mw_valid <= em_valid && em_cw.load_regfile;
		end
	end

	always_ff @(posedge clk) begin
		mw_dr <= em_dr;
		mw_data <= value;
		mw_cc <= value_cc;
	end

endmodule

// ==== source/lc3b_pipe.sv ====
`timescale 1ns/1ps

module lc3b_pipe import lc3b_pkg::*; (
	input logic clk,
	input logic rst,
	input logic prog_we,
	input lc3b_word prog_addr,
	input lc3b_word prog_data,
	output logic retire_valid,
	output lc3b_reg retire_dr,
	output lc3b_word retire_data,
	output lc3b_nzp retire_cc
);

	// hazard control
	logic stall;
	logic redirect;
	lc3b_word redirect_pc;

	// fetch/decode
	logic fd_valid;
	lc3b_word fd_pc;
	lc3b_word fd_ir;

	// register file read
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_word sr1_data;
	lc3b_word sr2_data;
	lc3b_nzp cc;

	// decode/execute
	logic de_valid;
	lc3b_control_word de_cw;
	lc3b_word de_pc;
	lc3b_word de_ir;
	lc3b_word de_op1;
	lc3b_word de_op2;
	lc3b_nzp de_cc;
	lc3b_reg de_dr;
	lc3b_reg de_sr1;
	lc3b_reg de_sr2;

	// forwarded operands
	lc3b_word op1;
	lc3b_word op2;

	// execute/memory
	logic em_valid;
	logic em_load_regfile;
	logic em_mem_read;
	lc3b_control_word em_cw;
	lc3b_reg em_dr;
	lc3b_word em_result;
	lc3b_word em_address;
	lc3b_word em_store_data;

	// memory/write back
	logic mw_valid;
	lc3b_reg mw_dr;
	lc3b_word mw_data;
	lc3b_nzp mw_cc;

	lc3b_fetch fetch_int (
		.clk, .rst, .prog_we, .prog_addr, .prog_data,
		.stall, .redirect, .redirect_pc,
		.fd_valid, .fd_pc, .fd_ir
	);

	lc3b_regfile regfile_int (
		.clk, .rst, .sr1, .sr2, .sr1_data, .sr2_data, .cc,
		.wb_valid(mw_valid), .wb_dr(mw_dr), .wb_data(mw_data), .wb_cc(mw_cc)
	);

	// load-use check looks at the decode/execute latch
	lc3b_decode decode_int (
		.clk, .rst, .fd_valid, .fd_pc, .fd_ir,
		.ex_valid(de_valid), .ex_dr(de_dr), .ex_mem_read(de_cw.mem_read),
		.redirect, .sr1, .sr2, .sr1_data, .sr2_data, .cc, .stall,
		.de_valid, .de_cw, .de_pc, .de_ir, .de_op1, .de_op2,
		.de_cc, .de_dr, .de_sr1, .de_sr2
	);

	lc3b_forward forward_int (
		.de_sr1, .de_sr2, .de_op1, .de_op2,
		.em_valid, .em_load_regfile, .em_mem_read, .em_dr, .em_result,
		.mw_valid, .mw_dr, .mw_data,
		.op1, .op2
	);

	lc3b_execute execute_int (
		.clk, .rst, .de_valid, .de_cw, .de_pc, .de_ir, .de_cc, .de_dr,
		.op1, .op2, .redirect, .redirect_pc,
		.em_valid, .em_load_regfile, .em_mem_read, .em_cw, .em_dr,
		.em_result, .em_address, .em_store_data
	);

	lc3b_memory memory_int (
		.clk, .rst, .em_valid, .em_cw, .em_dr, .em_result, .em_address, .em_store_data,
		.mw_valid, .mw_dr, .mw_data, .mw_cc
	);

	assign retire_valid = mw_valid;
	assign retire_dr = mw_dr;
	assign retire_data = mw_data;
	assign retire_cc = mw_cc;

endmodule

// ==== bench/lc3b_pipe_properties.sv ====
`timescale 1ns/1ps

module lc3b_pipe_properties (
	input logic clk,
	input logic rst,
	input logic entry_valid,
	input logic redirect,
	input logic stall
);

	// taken branch only from a real instruction
	redirect_on_valid: assert property (@(posedge clk) disable iff (rst)
		redirect |-> entry_valid)
		else $error("redirect raised on an invalid decode/execute entry");

	// fetch/decode latch is cleared after the first reset edge
	stall_quiet_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !stall)
		else $error("stall raised while reset is held");

	// first younger instruction squashed in decode
	flush_after_redirect: assert property (@(posedge clk) disable iff (rst)
		redirect |=> !entry_valid)
		else $error("decode/execute entry still valid after a redirect");

	// second one squashed in fetch
	flush_second_after_redirect: assert property (@(posedge clk) disable iff (rst)
		$past(redirect, 2) |-> !entry_valid)
		else $error("decode/execute entry valid two cycles after a redirect");

endmodule

bind lc3b_decode lc3b_pipe_properties decode_props (
	.clk, .rst, .entry_valid(de_valid), .redirect, .stall
);

// ==== bench/lc3b_pipe_tb.sv ====
`timescale 1ns/1ps

module lc3b_pipe_tb import lc3b_pkg::*; ();

	logic clk = 1'b0;
	logic rst;
	logic prog_we;
	lc3b_word prog_addr;
	lc3b_word prog_data;
	logic retire_valid;
	lc3b_reg retire_dr;
	lc3b_word retire_data;
	lc3b_nzp retire_cc;

	// header, program words, then dr/data/cc triples
	lc3b_word stim [0:255];
	int prog_len;
	int exp_count;
	int limit;
	int cycles = 0;
	int retired = 0;
	int errors = 0;

	lc3b_pipe UUT (
		.clk, .rst, .prog_we, .prog_addr, .prog_data,
		.retire_valid, .retire_dr, .retire_data, .retire_cc
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	task automatic check_reg(input string what, input lc3b_reg got, input lc3b_reg expected);
		if (got !== expected) begin
			$display("[FAIL] %0t: %s is R%0d, expected R%0d", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic check_word(input string what, input lc3b_word got, input lc3b_word expected);
		if (got !== expected) begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic check_cc(input string what, input lc3b_nzp got, input lc3b_nzp expected);
		if (got !== expected) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic check_retire();
		int base;
		base = 2 + prog_len + 3 * retired;
		check_reg($sformatf("retire %0d dr", retired), retire_dr, lc3b_reg'(stim[base]));
		check_word($sformatf("retire %0d data", retired), retire_data, stim[base + 1]);
		check_cc($sformatf("retire %0d cc", retired), retire_cc, lc3b_nzp'(stim[base + 2]));
	endtask

	// one word per cycle, byte addresses
	task automatic load_program();
		for (int i = 0; i < prog_len; i++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= lc3b_word'(2 * i);
			prog_data <= stim[2 + i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	// sample mid cycle, away from the driving edge
	always @(negedge clk) begin
		if (!rst && retire_valid) begin
			if (retired < exp_count) begin
				check_retire();
			end else begin
				$display("unexpected retirement of R%0d = %h at %0t", retire_dr, retire_data,
					$time);
				errors++;
			end
			retired++;
		end
	end

	initial begin
		rst <= 1'b1;
		prog_we <= 1'b0;
		prog_addr <= '0;
		prog_data <= '0;
		$readmemh("bench/lc3b_stimulus.txt", stim);
		prog_len = int'(stim[0]);
		exp_count = int'(stim[1]);
		// every word fetched once, plus stall and flush slack per retirement
		limit = prog_len + 2 * exp_count + 50;
		if (prog_len == 0 || exp_count == 0) begin
			$display("stimulus file holds no program or no expected retirements");
			errors++;
		end
		load_program();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		while (retired < exp_count && cycles < limit) begin
			@(posedge clk);
		end
		if (retired < exp_count) begin
			$display("timeout after %0d cycles, %0d of %0d expected retirements missing",
				cycles, exp_count - retired, exp_count);
			errors++;
		end else begin
			// window for stray retirements
			repeat (10) @(posedge clk);
		end
		$display("retired %0d of %0d expected entries, %0d errors", retired, exp_count, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== bench/lc3b_stimulus.txt ====
// header: program word count, expected retirement count; then program words in address order
// then one line per expected retirement in program order: dr data cc
001D 0010
0402 1FE1 1FE2 1225  // BRz over two ADDs on reset z, then R1 = 5
147D 1642 58E6 5B02  // dependent ADD/AND chain through both forward paths
9D7F 5020 E008 7601  // NOT, clear R0, LEA R0, STR R3 to R0+2
6801 1B04 9D7F 0802  // LDR then load-use ADD, NOT sets n, BRn taken
1FE1 1FE2 5260 0A02  // two skipped ADDs, AND sets z, BRnp not taken
127F 0601 1461 0401  // R1 = -1, BRzp not taken, R2 = 0, BRz taken
1FE1 6601 0201 1FE1  // skipped ADD, LDR R3, BRp on load cc taken, skipped ADD
18F9                 // R4 = R3 - 7
1 0005 1
2 0002 1
3 0007 1
4 0006 1
5 0002 1
6 FFFD 4
0 0000 2
0 0026 1
4 0007 1
5 000E 1
6 FFF1 4
1 0000 2
1 FFFF 4
2 0000 2
3 0007 1
4 0000 2

// ==== lc3b_pipe.f ====
source/lc3b_pkg.sv
source/lc3b_fetch.sv
source/lc3b_regfile.sv
source/lc3b_decode.sv
source/lc3b_forward.sv
source/lc3b_execute.sv
source/lc3b_memory.sv
source/lc3b_pipe.sv
bench/lc3b_pipe_properties.sv
bench/lc3b_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f lc3b_pipe.f --top-module lc3b_pipe_tb -o lc3b_sim \
	&& ./obj_dir/lc3b_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Test completed successfully" sim.log \
	|| { echo "pass message not found in sim.log"; exit 1; }
